//--- Makefile
# Verilator build and run for the vector ALU testbench

TOP = tb_valu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		-f tb.f --top-module $(TOP) -Mdir obj_dir

# Pass or fail comes from the log
run: compile
	obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_valu_model.svh
// Vector ALU reference model
`ifndef TB_VALU_MODEL_SVH
`define TB_VALU_MODEL_SVH

// Ones in the low w bits
function automatic logic [63:0] elem_mask(input int w);
  return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
endfunction

// Element idx of a word as a wide number, sign-extended when asked
function automatic logic signed [66:0] elem_value(input logic [63:0] word, input int w,
                                                  input int idx, input logic sgn);
  logic [63:0]        raw;
  logic signed [66:0] v;
  raw = (word >> (idx * w)) & elem_mask(w);
  v   = $signed({3'b000, raw});
  if (sgn && raw[w-1]) begin
    v = v - (67'sd1 <<< w);
  end
  return v;
endfunction

// Expected word and clamp flag of one 64-bit lane
function automatic void lane_expect(input valu_op_pkg::valu_op_e op,
                                    input valu_op_pkg::vew_e vew,
                                    input logic [63:0] a, input logic [63:0] b,
                                    output logic [63:0] res, output logic sat);
  int                 w;
  logic               sgn;
  logic               clamp;
  logic signed [66:0] ea, eb, r, lo, hi;
  w     = 8 << int'(vew);
  sgn   = op inside {valu_op_pkg::VSADD, valu_op_pkg::VSSUB, valu_op_pkg::VMIN,
                     valu_op_pkg::VMAX, valu_op_pkg::VMSLT, valu_op_pkg::VMSLE,
                     valu_op_pkg::VMSGT};
  clamp = op inside {valu_op_pkg::VSADDU, valu_op_pkg::VSADD, valu_op_pkg::VSSUBU,
                     valu_op_pkg::VSSUB};
  hi    = sgn ? (67'sd1 <<< (w - 1)) - 67'sd1 : (67'sd1 <<< w) - 67'sd1;
  lo    = sgn ? -(67'sd1 <<< (w - 1)) : 67'sd0;
  res   = '0;
  sat   = 1'b0;
  for (int i = 0; i < 64 / w; i++) begin
    ea = elem_value(a, w, i, sgn);
    eb = elem_value(b, w, i, sgn);
    case (op)
      valu_op_pkg::VADD, valu_op_pkg::VSADDU, valu_op_pkg::VSADD: r = ea + eb;
      valu_op_pkg::VSUB, valu_op_pkg::VSSUBU, valu_op_pkg::VSSUB: r = eb - ea;
      valu_op_pkg::VRSUB:                      r = ea - eb;
      valu_op_pkg::VAND:                       r = ea & eb;
      valu_op_pkg::VOR:                        r = ea | eb;
      valu_op_pkg::VXOR:                       r = ea ^ eb;
      valu_op_pkg::VMIN, valu_op_pkg::VMINU:   r = (eb < ea) ? eb : ea;
      valu_op_pkg::VMAX, valu_op_pkg::VMAXU:   r = (eb > ea) ? eb : ea;
      valu_op_pkg::VMSEQ:                      r = (eb == ea) ? 67'sd1 : 67'sd0;
      valu_op_pkg::VMSNE:                      r = (eb != ea) ? 67'sd1 : 67'sd0;
      valu_op_pkg::VMSLT, valu_op_pkg::VMSLTU: r = (eb < ea) ? 67'sd1 : 67'sd0;
      valu_op_pkg::VMSLE, valu_op_pkg::VMSLEU: r = (eb <= ea) ? 67'sd1 : 67'sd0;
      default:                                 r = (eb > ea) ? 67'sd1 : 67'sd0;
    endcase
    // Out of range results clamp to the nearest bound
    if (clamp && (r > hi)) begin
      r   = hi;
      sat = 1'b1;
    end
    if (clamp && (r < lo)) begin
      r   = lo;
      sat = 1'b1;
    end
    res = res | ((r[63:0] & elem_mask(w)) << (i * w));
  end
endfunction

// Whole vector, lanes are independent
function automatic void vector_expect(input valu_op_pkg::valu_op_e op,
                                      input valu_op_pkg::vew_e vew,
                                      input logic [VLEN-1:0] a, input logic [VLEN-1:0] b,
                                      output logic [VLEN-1:0] res, output logic sat);
  logic [63:0] lane_res;
  logic        lane_sat;
  res = '0;
  sat = 1'b0;
  for (int l = 0; l < NR_LANES; l++) begin
    lane_expect(op, vew, a[l*64 +: 64], b[l*64 +: 64], lane_res, lane_sat);
    res[l*64 +: 64] = lane_res;
    sat             = sat | lane_sat;
  end
endfunction

`endif

//--- bench/tb_valu.sv
// Vector ALU testbench
`timescale 1ns/10ps
`default_nettype none

module tb_valu;

  localparam int NR_LANES = 4;
  localparam int VLEN     = NR_LANES * 64;
  localparam int TIMEOUT  = 20;

  logic                  clk_i;
  logic                  rst_i;
  logic                  valid_i;
  valu_op_pkg::valu_op_e op_i;
  valu_op_pkg::vew_e     vew_i;
  logic [VLEN-1:0]       operand_a_i;
  logic [VLEN-1:0]       operand_b_i;
  logic                  valid_o;
  logic [VLEN-1:0]       result_o;
  logic                  vxsat_o;
  logic [31:0]           lfsr_q = 32'ha002;

  `include "tb_valu_model.svh"

  valu_top #(
    .NR_LANES(NR_LANES)
  ) dut0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .vew_i      (vew_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .vxsat_o    (vxsat_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic rand_vector(output logic [VLEN-1:0] v);
    logic [63:0] word;
    for (int l = 0; l < NR_LANES; l++) begin
      rand_bits(64, word);
      v[l*64 +: 64] = word;
    end
  endtask

  // 0 zero, 1 one, 2 all ones, 3 signed max, else signed min
  function automatic logic [63:0] corner(input int kind, input int w);
    case (kind)
      0:       return 64'd0;
      1:       return 64'd1;
      2:       return elem_mask(w);
      3:       return elem_mask(w) >> 1;
      default: return (elem_mask(w) >> 1) + 64'd1;
    endcase
  endfunction

  function automatic logic [VLEN-1:0] fill_elems(input logic [63:0] e, input int w);
    logic [VLEN-1:0] v;
    v = '0;
    for (int i = 0; i < VLEN / w; i++) begin
      v = v | (VLEN'(e & elem_mask(w)) << (i * w));
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [VLEN-1:0] actual,
                             input logic [VLEN-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  // One request, then wait for its result
  task automatic run_single(input valu_op_pkg::valu_op_e op, input valu_op_pkg::vew_e vew,
                            input logic [VLEN-1:0] a, input logic [VLEN-1:0] b);
    logic [VLEN-1:0] exp_res;
    logic            exp_sat;
    int              cycles;
    vector_expect(op, vew, a, b, exp_res, exp_sat);
    @(negedge clk_i);
    valid_i     = 1'b1;
    op_i        = op;
    vew_i       = vew;
    operand_a_i = a;
    operand_b_i = b;
    @(negedge clk_i);
    valid_i = 1'b0;
    cycles  = 1;
    while (!valid_o) begin
      if (cycles >= TIMEOUT) begin
        fail_run("Timed out waiting for valid_o after a single request");
      end
      @(negedge clk_i);
      cycles++;
    end
    check_value("latency", VLEN'(cycles), VLEN'(2));
    check_value("result_o", result_o, exp_res);
    check_value("vxsat_o", VLEN'(vxsat_o), VLEN'(exp_sat));
  endtask

  task automatic sweep_random(input valu_op_pkg::valu_op_e first,
                              input valu_op_pkg::valu_op_e last, input int count);
    logic [VLEN-1:0] a, b;
    for (int v = 0; v < 4; v++) begin
      for (int k = int'(first); k <= int'(last); k++) begin
        for (int n = 0; n < count; n++) begin
          rand_vector(a);
          rand_vector(b);
          run_single(valu_op_pkg::valu_op_e'(5'(k)), valu_op_pkg::vew_e'(2'(v)), a, b);
        end
      end
    end
  endtask

  task automatic sweep_corners(input valu_op_pkg::valu_op_e first,
                               input valu_op_pkg::valu_op_e last,
                               input int kind_a, input int kind_b);
    int w;
    for (int v = 0; v < 4; v++) begin
      w = 8 << v;
      for (int k = int'(first); k <= int'(last); k++) begin
        run_single(valu_op_pkg::valu_op_e'(5'(k)), valu_op_pkg::vew_e'(2'(v)),
                   fill_elems(corner(kind_a, w), w), fill_elems(corner(kind_b, w), w));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_logic();
    logic [VLEN-1:0] a, b;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      check_value("valid_o after reset", VLEN'(valid_o), '0);
    end
    rand_vector(a);
    rand_vector(b);
    run_single(valu_op_pkg::VAND, valu_op_pkg::EW64, a, b);
    run_single(valu_op_pkg::VOR, valu_op_pkg::EW64, a, b);
    run_single(valu_op_pkg::VXOR, valu_op_pkg::EW64, a, b);
  endtask

  task automatic test_add_sub();
    sweep_random(valu_op_pkg::VADD, valu_op_pkg::VRSUB, 3);
    // Wraparound at both ends
    sweep_corners(valu_op_pkg::VADD, valu_op_pkg::VRSUB, 2, 1);
    sweep_corners(valu_op_pkg::VADD, valu_op_pkg::VRSUB, 1, 0);
  endtask

  task automatic test_saturate();
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 2, 1);
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 3, 1);
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 4, 4);
    // Signed min minus one, signed max minus minus one
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 1, 4);
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 2, 3);
    sweep_corners(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 1, 0);
    sweep_random(valu_op_pkg::VSADDU, valu_op_pkg::VSSUB, 2);
  endtask

  task automatic test_min_max();
    sweep_random(valu_op_pkg::VMIN, valu_op_pkg::VMAXU, 3);
    sweep_corners(valu_op_pkg::VMIN, valu_op_pkg::VMAXU, 4, 1);
    sweep_corners(valu_op_pkg::VMIN, valu_op_pkg::VMAXU, 1, 2);
  endtask

  task automatic test_compare();
    sweep_random(valu_op_pkg::VMSEQ, valu_op_pkg::VMSGTU, 2);
    sweep_corners(valu_op_pkg::VMSEQ, valu_op_pkg::VMSGTU, 3, 3);
    sweep_corners(valu_op_pkg::VMSEQ, valu_op_pkg::VMSGTU, 0, 1);
    sweep_corners(valu_op_pkg::VMSEQ, valu_op_pkg::VMSGTU, 1, 0);
    sweep_corners(valu_op_pkg::VMSEQ, valu_op_pkg::VMSGTU, 4, 1);
  endtask

  // New request every cycle, results checked in order
  task automatic test_back_to_back();
    logic [VLEN-1:0] a, b, exp_res;
    logic [63:0]     pick;
    logic            exp_sat;
    logic [VLEN-1:0] res_q [$];
    logic            sat_q [$];
    int              cyc_q [$];
    int              got;
    got = 0;
    for (int c = 0; (c < 10 + TIMEOUT) && (got < 10); c++) begin
      @(negedge clk_i);
      if (valid_o) begin
        if (res_q.size() == 0) begin
          fail_run("valid_o went high with no request pending");
        end
        check_value("latency", VLEN'(c - cyc_q.pop_front()), VLEN'(2));
        check_value("result_o", result_o, res_q.pop_front());
        check_value("vxsat_o", VLEN'(vxsat_o), VLEN'(sat_q.pop_front()));
        got++;
      end
      valid_i = 1'b0;
      if (c < 10) begin
        rand_bits(5, pick);
        op_i = valu_op_pkg::valu_op_e'(5'(pick % 22));
        rand_bits(2, pick);
        vew_i = valu_op_pkg::vew_e'(pick[1:0]);
        rand_vector(a);
        rand_vector(b);
        operand_a_i = a;
        operand_b_i = b;
        valid_i     = 1'b1;
        vector_expect(op_i, vew_i, a, b, exp_res, exp_sat);
        res_q.push_back(exp_res);
        sat_q.push_back(exp_sat);
        cyc_q.push_back(c);
      end
    end
    if (got != 10) begin
      fail_run("Timed out waiting for back-to-back results");
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    valid_i     = 1'b0;
    op_i        = valu_op_pkg::VADD;
    vew_i       = valu_op_pkg::EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_reset_logic();
    test_add_sub();
    test_saturate();
    test_min_max();
    test_compare();
    test_back_to_back();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- common/valu_data_pkg.sv
// Vector ALU word types
`default_nettype none

package valu_data_pkg;

  localparam int unsigned ELEN       = 64;
  localparam int unsigned ELEN_BYTES = ELEN / 8;

  typedef logic [ELEN-1:0] elen_t;

  // One word seen as 1, 2, 4 or 8 elements
  typedef union packed {
    logic [0:0][ELEN-1:0]   w64;
    logic [1:0][ELEN/2-1:0] w32;
    logic [3:0][ELEN/4-1:0] w16;
    logic [7:0][ELEN/8-1:0] w8;
  } valu_word_u;

  // One bit per byte, all bytes of a clamped element set
  typedef logic [ELEN_BYTES-1:0] vxsat_t;

endpackage

`default_nettype wire

//--- common/valu_lane_if.sv
// Dispatch to lane link
`timescale 1ns/10ps
`default_nettype none

interface valu_lane_if;

  valu_op_pkg::valu_op_e op;
  valu_op_pkg::vew_e     vew;
  valu_data_pkg::elen_t  operand_a;
  valu_data_pkg::elen_t  operand_b;

  modport dispatch (
    output op, vew, operand_a, operand_b
  );

  modport lane (
    input op, vew, operand_a, operand_b
  );

endinterface

`default_nettype wire

//--- common/valu_op_pkg.sv
// Vector ALU operation codes
`default_nettype none

package valu_op_pkg;

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAND, VOR, VXOR,
    VMIN, VMINU, VMAX, VMAXU,
    VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU
  } valu_op_e;

  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } vew_e;

  // Signed compare, min/max or saturation
  function automatic logic is_signed(valu_op_e op);
    return op inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
  endfunction

  function automatic logic is_sat(valu_op_e op);
    return op inside {VSADDU, VSADD, VSSUBU, VSSUB};
  endfunction

  function automatic logic is_sub(valu_op_e op);
    return op inside {VSUB, VRSUB, VSSUBU, VSSUB};
  endfunction

  function automatic logic is_addsub(valu_op_e op);
    return op inside {VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB};
  endfunction

  function automatic logic is_cmp(valu_op_e op);
    return op inside {VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU};
  endfunction

endpackage

`default_nettype wire

//--- lane/valu_lane.sv
// Single 64-bit ALU lane
`timescale 1ns/10ps
`default_nettype none

module valu_lane (
  valu_lane_if.lane             lane_i,
  output valu_data_pkg::elen_t  result_o,
  output valu_data_pkg::vxsat_t vxsat_o
);

  valu_data_pkg::elen_t  sum;
  valu_data_pkg::elen_t  cmp_result;
  valu_data_pkg::vxsat_t ovf;

  valu_lane_addsub i_addsub (
    .op_i       (lane_i.op),
    .vew_i      (lane_i.vew),
    .operand_a_i(lane_i.operand_a),
    .operand_b_i(lane_i.operand_b),
    .sum_o      (sum),
    .vxsat_o    (ovf)
  );

  valu_lane_cmp i_cmp (
    .op_i       (lane_i.op),
    .vew_i      (lane_i.vew),
    .operand_a_i(lane_i.operand_a),
    .operand_b_i(lane_i.operand_b),
    .result_o   (cmp_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_select
    unique case (lane_i.op)
      valu_op_pkg::VAND: result_o = lane_i.operand_a & lane_i.operand_b;
      valu_op_pkg::VOR:  result_o = lane_i.operand_a | lane_i.operand_b;
      valu_op_pkg::VXOR: result_o = lane_i.operand_a ^ lane_i.operand_b;
      // Min/max and compares share the compare unit
      default: result_o = valu_op_pkg::is_addsub(lane_i.op) ? sum : cmp_result;
    endcase
  end

  // Plain add/sub overflow is not a saturation event
  assign vxsat_o = valu_op_pkg::is_sat(lane_i.op) ? ovf : '0;

endmodule

`default_nettype wire

//--- lane/valu_lane_addsub.sv
// Element-wise add and subtract
`timescale 1ns/10ps
`default_nettype none

module valu_lane_addsub (
  input  valu_op_pkg::valu_op_e op_i,
  input  valu_op_pkg::vew_e     vew_i,
  input  valu_data_pkg::elen_t  operand_a_i,
  input  valu_data_pkg::elen_t  operand_b_i,
  output valu_data_pkg::elen_t  sum_o,
  output valu_data_pkg::vxsat_t vxsat_o
);

  valu_data_pkg::valu_word_u x, y, res;
  valu_data_pkg::vxsat_t     ovf_bytes;
  logic                      swap, sub_op, sgn, sat_op, ovf;
  logic [8:0]                ext8;
  logic [16:0]               ext16;
  logic [32:0]               ext32;
  logic [64:0]               ext64;

  // VSUB and the saturating subtracts take B minus A
  assign swap   = op_i inside {valu_op_pkg::VSUB, valu_op_pkg::VSSUBU, valu_op_pkg::VSSUB};
  assign x      = swap ? operand_b_i : operand_a_i;
  assign y      = swap ? operand_a_i : operand_b_i;
  assign sub_op = valu_op_pkg::is_sub(op_i);
  assign sgn    = valu_op_pkg::is_signed(op_i);
  assign sat_op = valu_op_pkg::is_sat(op_i);

  // Signed overflow: operand signs agree (add) or differ (sub) and result sign flips
  always_comb begin : p_addsub
    res       = '0;
    ovf_bytes = '0;
    ovf       = 1'b0;
    ext8      = '0;
    ext16     = '0;
    ext32     = '0;
    ext64     = '0;
    unique case (vew_i)
      valu_op_pkg::EW8: for (int e = 0; e < 8; e++) begin
        ext8 = sub_op ? {1'b0, x.w8[e]} - {1'b0, y.w8[e]} : {1'b0, x.w8[e]} + {1'b0, y.w8[e]};
        ovf  = sgn ? ((x.w8[e][7] ^ y.w8[e][7]) == sub_op) && (ext8[7] != x.w8[e][7])
                   : ext8[8];
        res.w8[e] = ext8[7:0];
        if (ovf) begin
          ovf_bytes[e] = 1'b1;
          if (sat_op) res.w8[e] = sgn ? {x.w8[e][7], {7{~x.w8[e][7]}}} : {8{~sub_op}};
        end
      end
      valu_op_pkg::EW16: for (int e = 0; e < 4; e++) begin
        ext16 = sub_op ? {1'b0, x.w16[e]} - {1'b0, y.w16[e]}
                       : {1'b0, x.w16[e]} + {1'b0, y.w16[e]};
        ovf   = sgn ? ((x.w16[e][15] ^ y.w16[e][15]) == sub_op) && (ext16[15] != x.w16[e][15])
                    : ext16[16];
        res.w16[e] = ext16[15:0];
        if (ovf) begin
          ovf_bytes[2*e +: 2] = '1;
          if (sat_op) res.w16[e] = sgn ? {x.w16[e][15], {15{~x.w16[e][15]}}} : {16{~sub_op}};
        end
      end
      valu_op_pkg::EW32: for (int e = 0; e < 2; e++) begin
        ext32 = sub_op ? {1'b0, x.w32[e]} - {1'b0, y.w32[e]}
                       : {1'b0, x.w32[e]} + {1'b0, y.w32[e]};
        ovf   = sgn ? ((x.w32[e][31] ^ y.w32[e][31]) == sub_op) && (ext32[31] != x.w32[e][31])
                    : ext32[32];
        res.w32[e] = ext32[31:0];
        if (ovf) begin
          ovf_bytes[4*e +: 4] = '1;
          if (sat_op) res.w32[e] = sgn ? {x.w32[e][31], {31{~x.w32[e][31]}}} : {32{~sub_op}};
        end
      end
      valu_op_pkg::EW64: begin
        ext64 = sub_op ? {1'b0, x.w64[0]} - {1'b0, y.w64[0]}
                       : {1'b0, x.w64[0]} + {1'b0, y.w64[0]};
        ovf   = sgn ? ((x.w64[0][63] ^ y.w64[0][63]) == sub_op) && (ext64[63] != x.w64[0][63])
                    : ext64[64];
        res.w64[0] = ext64[63:0];
        if (ovf) begin
          ovf_bytes = '1;
          if (sat_op) res.w64[0] = sgn ? {x.w64[0][63], {63{~x.w64[0][63]}}} : {64{~sub_op}};
        end
      end
    endcase
  end

  assign sum_o   = res;
  assign vxsat_o = ovf_bytes;

endmodule

`default_nettype wire

//--- lane/valu_lane_cmp.sv
// Element-wise compare and min/max
`timescale 1ns/10ps
`default_nettype none

module valu_lane_cmp (
  input  valu_op_pkg::valu_op_e op_i,
  input  valu_op_pkg::vew_e     vew_i,
  input  valu_data_pkg::elen_t  operand_a_i,
  input  valu_data_pkg::elen_t  operand_b_i,
  output valu_data_pkg::elen_t  result_o
);

  valu_data_pkg::valu_word_u opa, opb, res;
  logic                      sgn, is_max, is_cmp;
  // Flags sit at the first byte of each element
  logic [7:0]                less, equal, le, flag;

  assign opa    = operand_a_i;
  assign opb    = operand_b_i;
  assign sgn    = valu_op_pkg::is_signed(op_i);
  assign is_max = op_i inside {valu_op_pkg::VMAX, valu_op_pkg::VMAXU};
  assign is_cmp = valu_op_pkg::is_cmp(op_i);

  // B less than A, one extra bit carries the sign when signed
  always_comb begin : p_less_equal
    less  = '0;
    equal = '0;
    unique case (vew_i)
      valu_op_pkg::EW8: for (int e = 0; e < 8; e++) begin
        less[e]  = $signed({sgn & opb.w8[e][7], opb.w8[e]}) <
                   $signed({sgn & opa.w8[e][7], opa.w8[e]});
        equal[e] = opb.w8[e] == opa.w8[e];
      end
      valu_op_pkg::EW16: for (int e = 0; e < 4; e++) begin
        less[2*e]  = $signed({sgn & opb.w16[e][15], opb.w16[e]}) <
                     $signed({sgn & opa.w16[e][15], opa.w16[e]});
        equal[2*e] = opb.w16[e] == opa.w16[e];
      end
      valu_op_pkg::EW32: for (int e = 0; e < 2; e++) begin
        less[4*e]  = $signed({sgn & opb.w32[e][31], opb.w32[e]}) <
                     $signed({sgn & opa.w32[e][31], opa.w32[e]});
        equal[4*e] = opb.w32[e] == opa.w32[e];
      end
      valu_op_pkg::EW64: begin
        less[0]  = $signed({sgn & opb.w64[0][63], opb.w64[0]}) <
                   $signed({sgn & opa.w64[0][63], opa.w64[0]});
        equal[0] = opb.w64[0] == opa.w64[0];
      end
    endcase
  end

  assign le = less | equal;

  // Compare bit, or for min/max the pick of operand B
  always_comb begin : p_flag
    unique case (op_i)
      valu_op_pkg::VMSEQ:                      flag = equal;
      valu_op_pkg::VMSNE:                      flag = ~equal;
      valu_op_pkg::VMSLT, valu_op_pkg::VMSLTU: flag = less;
      valu_op_pkg::VMSLE, valu_op_pkg::VMSLEU: flag = le;
      valu_op_pkg::VMSGT, valu_op_pkg::VMSGTU: flag = ~le;
      default:                                 flag = less ^ {8{is_max}};
    endcase
  end

  always_comb begin : p_result
    res = '0;
    unique case (vew_i)
      valu_op_pkg::EW8: for (int e = 0; e < 8; e++) begin
        res.w8[e] = is_cmp ? 8'(flag[e]) : (flag[e] ? opb.w8[e] : opa.w8[e]);
      end
      valu_op_pkg::EW16: for (int e = 0; e < 4; e++) begin
        res.w16[e] = is_cmp ? 16'(flag[2*e]) : (flag[2*e] ? opb.w16[e] : opa.w16[e]);
      end
      valu_op_pkg::EW32: for (int e = 0; e < 2; e++) begin
        res.w32[e] = is_cmp ? 32'(flag[4*e]) : (flag[4*e] ? opb.w32[e] : opa.w32[e]);
      end
      valu_op_pkg::EW64: begin
        res.w64[0] = is_cmp ? 64'(flag[0]) : (flag[0] ? opb.w64[0] : opa.w64[0]);
      end
    endcase
  end

  assign result_o = res;

endmodule

`default_nettype wire

//--- src/valu_collect.sv
// Lane result collect stage
`timescale 1ns/10ps
`default_nettype none

module valu_collect #(
  parameter  int unsigned NR_LANES = 4,
  localparam int unsigned VLEN     = NR_LANES * valu_data_pkg::ELEN
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 valid_i,
  input  valu_data_pkg::elen_t  [NR_LANES-1:0] lane_result_i,
  input  valu_data_pkg::vxsat_t [NR_LANES-1:0] lane_vxsat_i,
  output logic                                 valid_o,
  output logic [VLEN-1:0]                      result_o,
  output logic                                 vxsat_o
);

  logic            valid_q;
  logic [VLEN-1:0] result_q;
  logic            vxsat_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Any clamped byte in any lane raises the flag
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= lane_result_i;
      vxsat_q  <= |lane_vxsat_i;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;

  a_valid_known: assert property (
    @(posedge clk_i) disable iff (rst_i) !$isunknown(valid_o)
  );

endmodule

`default_nettype wire

//--- src/valu_dispatch.sv
// Request dispatch stage
`timescale 1ns/10ps
`default_nettype none

module valu_dispatch #(
  parameter  int unsigned NR_LANES = 4,
  localparam int unsigned VLEN     = NR_LANES * valu_data_pkg::ELEN
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  valu_op_pkg::valu_op_e op_i,
  input  valu_op_pkg::vew_e     vew_i,
  input  logic [VLEN-1:0]       operand_a_i,
  input  logic [VLEN-1:0]       operand_b_i,
  output logic                  valid_o,
  valu_lane_if.dispatch         lane_o [NR_LANES]
);

  logic                  valid_q;
  valu_op_pkg::valu_op_e op_q;
  valu_op_pkg::vew_e     vew_q;
  logic [VLEN-1:0]       operand_a_q;
  logic [VLEN-1:0]       operand_b_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a request strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_q        <= op_i;
      vew_q       <= vew_i;
      operand_a_q <= operand_a_i;
      operand_b_q <= operand_b_i;
    end
  end

  assign valid_o = valid_q;

  // Same op and width to all lanes, one word each
  for (genvar l = 0; l < NR_LANES; l++) begin : g_lane
    assign lane_o[l].op        = op_q;
    assign lane_o[l].vew       = vew_q;
    assign lane_o[l].operand_a = operand_a_q[l*valu_data_pkg::ELEN +: valu_data_pkg::ELEN];
    assign lane_o[l].operand_b = operand_b_q[l*valu_data_pkg::ELEN +: valu_data_pkg::ELEN];
  end

  a_ctrl_known: assert property (
    @(posedge clk_i) disable iff (rst_i) valid_i |-> !$isunknown({op_i, vew_i})
  );

endmodule

`default_nettype wire

//--- src/valu_top.sv
// SIMD vector ALU top level
`timescale 1ns/10ps
`default_nettype none

module valu_top #(
  parameter  int unsigned NR_LANES = 4,
  localparam int unsigned VLEN     = NR_LANES * valu_data_pkg::ELEN
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  valu_op_pkg::valu_op_e op_i,
  input  valu_op_pkg::vew_e     vew_i,
  input  logic [VLEN-1:0]       operand_a_i,
  input  logic [VLEN-1:0]       operand_b_i,
  output logic                  valid_o,
  output logic [VLEN-1:0]       result_o,
  output logic                  vxsat_o
);

  logic                                 disp_valid;
  valu_data_pkg::elen_t  [NR_LANES-1:0] lane_result;
  valu_data_pkg::vxsat_t [NR_LANES-1:0] lane_vxsat;

  valu_lane_if lane_if [NR_LANES] ();

  valu_dispatch #(
    .NR_LANES(NR_LANES)
  ) i_dispatch (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .vew_i      (vew_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .valid_o    (disp_valid),
    .lane_o     (lane_if)
  );

  for (genvar l = 0; l < NR_LANES; l++) begin : g_lane
    valu_lane i_lane (
      .lane_i  (lane_if[l]),
      .result_o(lane_result[l]),
      .vxsat_o (lane_vxsat[l])
    );
  end

  valu_collect #(
    .NR_LANES(NR_LANES)
  ) i_collect (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (disp_valid),
    .lane_result_i(lane_result),
    .lane_vxsat_i (lane_vxsat),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .vxsat_o      (vxsat_o)
  );

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
common/valu_op_pkg.sv
common/valu_data_pkg.sv
common/valu_lane_if.sv
lane/valu_lane_addsub.sv
lane/valu_lane_cmp.sv
lane/valu_lane.sv
src/valu_dispatch.sv
src/valu_collect.sv
src/valu_top.sv
bench/tb_valu.sv
